// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f src.f --top-module rsStoreTb -Mdir obj_dir -o rsStoreSim
	./obj_dir/rsStoreSim

clean:
	rm -rf obj_dir

// ==== bench/rsStoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rsParams.svh"

module rsStoreTb import rsPkg::*; ();

  localparam int N = `RS_ENTRIES;
  localparam int NUM_INSTR = 4000;
  localparam int WATCHDOG_CYCLES = NUM_INSTR * 5 + 2000;

  logic clk, rstN, stall, flush, allocValid, allocReady, issueValid;
  logic allocAReady, allocBReady;
  storeOp_e allocOp, issueOp, expOp;
  logic [`CONST_WIDTH-1:0] allocConst, issueConst, expConst;
  logic [`INDEX_WIDTH-1:0] allocIndex, issueIndex, expIndex;
  data_t allocAData, allocBData, issueDataA, issueDataB, expA, expB;
  tag_t allocATag, allocBTag;
  logic [`RESULT_BUSES-1:0] resultValid;
  tag_t [`RESULT_BUSES-1:0] resultTag;
  data_t [`RESULT_BUSES-1:0] resultData;

  // model of the entry array
  entryState_e mState [N];
  storeOp_e mOp [N];
  logic [`CONST_WIDTH-1:0] mConst [N];
  logic [`INDEX_WIDTH-1:0] mIndex [N];
  logic mHave [N][2];
  tag_t mTag [N][2];
  data_t mData [N][2];
  logic expValid;
  logic [31:0] rng = 32'h04fe_43c1;
  int allocCount = 0;

  rsStore uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic int lowestFree();
    for (int i = 0; i < N; i++) begin
      if (mState[i] == entFree) return i;
    end
    return -1;
  endfunction

  function automatic int lowestReady();
    for (int i = 0; i < N; i++) begin
      if (mState[i] == entReady) return i;
    end
    return -1;
  endfunction

  // one clock edge of the model, fed by the inputs of the cycle just ended
  task automatic modelStep();
    int w;
    int p;
    w = (allocValid && !stall && lowestFree() >= 0) ? lowestFree() : -1;
    p = (!stall && !flush) ? lowestReady() : -1;
    expValid = rstN && (p >= 0);
    if (expValid) begin
      expOp = mOp[p];
      expA = mData[p][0];
      expB = mData[p][1];
      expConst = mConst[p];
      expIndex = mIndex[p];
    end
    for (int i = 0; i < N; i++) begin
      if (i == w) begin
        mOp[i] = allocOp;
        mConst[i] = allocConst;
        mIndex[i] = allocIndex;
        mHave[i][0] = allocAReady;
        mHave[i][1] = allocBReady;
        mTag[i][0] = allocATag;
        mTag[i][1] = allocBTag;
        mData[i][0] = allocAData;
        mData[i][1] = allocBData;
      end
      if (i == w || mState[i] == entWaiting) begin
        for (int k = 0; k < 2; k++) begin
          for (int b = 0; b < `RESULT_BUSES; b++) begin
            if (!mHave[i][k] && resultValid[b] && resultTag[b] == mTag[i][k]) begin
              mData[i][k] = resultData[b];
              mHave[i][k] = 1'b1;
            end
          end
        end
      end
      if (!rstN || flush) mState[i] = entFree;
      else if (i == w || mState[i] == entWaiting)
        mState[i] = (mHave[i][0] && mHave[i][1]) ? entReady : entWaiting;
      else if (i == p) mState[i] = entFree;
    end
  endtask

  task automatic tick();
    @(posedge clk);
    modelStep();
  endtask

  task automatic quiet();
    tick();
    stall <= 1'b0;
    flush <= 1'b0;
    allocValid <= 1'b0;
    resultValid <= '0;
  endtask

  // tags 10 and 11 lie outside the random pool
  task automatic allocOne(input logic aRdy, input logic bRdy);
    logic [31:0] r;
    quiet();
    r = rand32();
    allocValid <= 1'b1;
    allocOp <= storeOp_e'(r[1:0]);
    allocConst <= r[31:16];
    allocIndex <= r[15:8];
    allocAReady <= aRdy;
    allocBReady <= bRdy;
    allocATag <= tag_t'(10);
    allocBTag <= tag_t'(11);
    allocAData <= rand32();
    allocBData <= rand32();
  endtask

  task automatic broadcast(input int t);
    quiet();
    resultValid <= 2'b01;
    resultTag[0] <= tag_t'(t);
    resultData[0] <= rand32();
  endtask

  task automatic randomCycle();
    logic [31:0] r;
    logic st;
    logic [1:0] t0;
    logic [1:0] t1;
    tick();
    r = rand32();
    st = (r % 10) == 0;
    stall <= st;
    flush <= (rand32() % 100) == 0;
    allocValid <= 1'b0;
    if (!st && lowestFree() >= 0 && (rand32() % 4) != 0) begin
      allocValid <= 1'b1;
      allocCount++;
    end
    allocOp <= storeOp_e'(r[1:0]);
    allocAReady <= r[2];
    allocBReady <= r[3];
    allocATag <= tag_t'(r[5:4]); // small pool of live tags
    allocBTag <= tag_t'(r[7:6]);
    allocConst <= r[31:16];
    allocIndex <= r[15:8];
    allocAData <= rand32();
    allocBData <= rand32();
    r = rand32();
    t0 = r[3:2];
    t1 = (r[5:4] == t0) ? t0 ^ 2'b01 : r[5:4];
    resultValid <= r[1:0];
    resultTag[0] <= tag_t'(t0);
    resultTag[1] <= tag_t'(t1);
    resultData[0] <= rand32();
    resultData[1] <= rand32();
  endtask

  task automatic reportMismatch(input string what);
    $display("Mismatch at %0t: %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on a mismatch");
  endtask

  always @(negedge clk) begin
    if (rstN) begin
      assert (issueValid === expValid) else reportMismatch("issueValid differs from model");
      assert (allocReady === (!stall && lowestFree() >= 0))
        else reportMismatch("allocReady differs from model");
      if (expValid) begin
        assert (issueOp === expOp && issueDataA === expA && issueDataB === expB &&
                issueConst === expConst && issueIndex === expIndex)
          else reportMismatch("issued payload differs from model");
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the test finished");
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

  initial begin
    rstN = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    allocValid = 1'b0;
    allocOp = opStoreByte;
    allocConst = '0;
    allocIndex = '0;
    allocAReady = 1'b0;
    allocAData = '0;
    allocATag = '0;
    allocBReady = 1'b0;
    allocBData = '0;
    allocBTag = '0;
    resultValid = '0;
    resultTag = '0;
    resultData = '0;
    repeat (10) tick();
    rstN <= 1'b1;
    repeat (10) quiet();
    allocOne(1'b1, 1'b1); // direct issue
    repeat (4) quiet();
    allocOne(1'b0, 1'b1);
    resultValid <= 2'b10; // same-edge wake-up of A
    resultTag[1] <= tag_t'(10);
    resultData[1] <= rand32();
    allocOne(1'b0, 1'b0);
    broadcast(11);
    broadcast(10);
    repeat (4) quiet();
    repeat (N) allocOne(1'b0, 1'b0); // fill the station
    quiet();
    @(negedge clk);
    assert (!allocReady) else reportMismatch("allocReady high with every entry in use");
    broadcast(10);
    broadcast(11);
    repeat (N + 4) quiet();
    allocOne(1'b1, 1'b1);
    allocOne(1'b0, 1'b0);
    stall <= 1'b1; // holds the ready entry and drops this request
    repeat (2) allocOne(1'b0, 1'b0);
    allocOne(1'b1, 1'b1);
    allocOne(1'b1, 1'b1);
    flush <= 1'b1; // beats this allocation and the pending issue
    broadcast(10);
    broadcast(11);
    repeat (4) quiet();
    while (allocCount < NUM_INSTR) randomCycle();
    repeat (10) quiet();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/rsAlloc.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rsParams.svh"

module rsAlloc import rsPkg::*; (
  input  entryMask_t freeMask,
  input  logic       allocValid,
  input  logic       stall,
  output entryMask_t writeSel,
  output logic       allocReady
);

  entryMask_t lowestFree;
  logic found;

  // priority scan from entry 0 upward
  always_comb begin
    lowestFree = '0;
    found = 1'b0;
    for (int i = 0; i < `RS_ENTRIES; i++) begin
      if (freeMask[i] && !found) begin
        lowestFree[i] = 1'b1;
        found = 1'b1;
      end
    end
  end

  assign allocReady = found & ~stall;

  // a request without allocReady is dropped here
  assign writeSel = (allocValid && allocReady) ? lowestFree : '0;

endmodule

`default_nettype wire

// ==== source/rsEntry.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rsParams.svh"

module rsEntry import rsPkg::*; (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             flush,
  input  logic                             writeEn,
  input  storeOp_e                         allocOp,
  input  logic [`CONST_WIDTH-1:0]          allocConst,
  input  logic [`INDEX_WIDTH-1:0]          allocIndex,
  input  logic                             allocAReady,
  input  data_t                            allocAData,
  input  tag_t                             allocATag,
  input  logic                             allocBReady,
  input  data_t                            allocBData,
  input  tag_t                             allocBTag,
  input  logic [`RESULT_BUSES-1:0]         resultValid,
  input  tag_t [`RESULT_BUSES-1:0]         resultTag,
  input  data_t [`RESULT_BUSES-1:0]        resultData,
  input  logic                             issueEn,
  output logic                             isFree,
  output logic                             isReady,
  output storeOp_e                         entOp,
  output data_t                            entDataA,
  output data_t                            entDataB,
  output logic [`CONST_WIDTH-1:0]          entConst,
  output logic [`INDEX_WIDTH-1:0]          entIndex
);

  entryState_e state, nextState;

  // operand 0 is A (address base), 1 is B (store data)
  logic  opPresent [2];
  tag_t  opTag [2];
  data_t opData [2];

  logic  srcPresent [2];
  tag_t  srcTag [2];
  data_t srcData [2];
  logic  hit [2];
  data_t nextData [2];
  logic  bothPresent;
  logic  capture;

  // on allocation the incoming fields stand in for the stored ones
  always_comb begin
    srcPresent[0] = writeEn ? allocAReady : opPresent[0];
    srcPresent[1] = writeEn ? allocBReady : opPresent[1];
    srcTag[0] = writeEn ? allocATag : opTag[0];
    srcTag[1] = writeEn ? allocBTag : opTag[1];
    srcData[0] = writeEn ? allocAData : opData[0];
    srcData[1] = writeEn ? allocBData : opData[1];
    for (int k = 0; k < 2; k++) begin
      hit[k] = 1'b0;
      nextData[k] = srcData[k];
      for (int b = 0; b < `RESULT_BUSES; b++) begin
        if (!srcPresent[k] && resultValid[b] && resultTag[b] == srcTag[k]) begin
          hit[k] = 1'b1;
          nextData[k] = resultData[b];
        end
      end
    end
  end

  assign bothPresent = (srcPresent[0] | hit[0]) & (srcPresent[1] | hit[1]);
  assign capture = writeEn | (state == entWaiting);

  always_comb begin
    nextState = state;
    if (flush) begin
      nextState = entFree; // beats a same-cycle allocation
    end else if (writeEn) begin
      nextState = bothPresent ? entReady : entWaiting;
    end else if (issueEn) begin
      nextState = entFree;
    end else if (state == entWaiting && bothPresent) begin
      nextState = entReady;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= entFree;
      opPresent[0] <= 1'b0;
      opPresent[1] <= 1'b0;
    end else begin
      state <= nextState;
      if (capture) begin
        for (int k = 0; k < 2; k++) begin
          opPresent[k] <= srcPresent[k] | hit[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (writeEn) begin
      entOp <= allocOp;
      entConst <= allocConst;
      entIndex <= allocIndex;
      opTag[0] <= allocATag;
      opTag[1] <= allocBTag;
    end
    if (capture) begin
      for (int k = 0; k < 2; k++) begin
        opData[k] <= nextData[k];
      end
    end
  end

  assign isFree = (state == entFree);
  assign isReady = (state == entReady);
  assign entDataA = opData[0];
  assign entDataB = opData[1];

endmodule

`default_nettype wire

// ==== source/rsIssue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rsParams.svh"

module rsIssue import rsPkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    stall,
  input  logic                    flush,
  input  entryMask_t              readyMask,
  input  storeOp_e                entOp [`RS_ENTRIES],
  input  data_t                   entDataA [`RS_ENTRIES],
  input  data_t                   entDataB [`RS_ENTRIES],
  input  logic [`CONST_WIDTH-1:0] entConst [`RS_ENTRIES],
  input  logic [`INDEX_WIDTH-1:0] entIndex [`RS_ENTRIES],
  output entryMask_t              issueSel,
  output logic                    issueValid,
  output storeOp_e                issueOp,
  output data_t                   issueDataA,
  output data_t                   issueDataB,
  output logic [`CONST_WIDTH-1:0] issueConst,
  output logic [`INDEX_WIDTH-1:0] issueIndex
);

  localparam int SEL_W = $clog2(`RS_ENTRIES);

  logic [SEL_W-1:0] pickIdx;
  logic anyReady;
  logic doIssue;

  // scan downward so the lowest ready index wins
  always_comb begin
    pickIdx = '0;
    anyReady = 1'b0;
    for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
      if (readyMask[i]) begin
        pickIdx = SEL_W'(i);
        anyReady = 1'b1;
      end
    end
  end

  assign doIssue = anyReady & ~stall & ~flush;

  // frees the chosen entry on this edge
  assign issueSel = doIssue ? (entryMask_t'(1) << pickIdx) : '0;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      issueValid <= 1'b0;
    end else begin
      issueValid <= doIssue; // single-cycle pulse per entry
    end
  end

  // payload holds its last value between issues
  always_ff @(posedge clk) begin
    if (doIssue) begin
      issueOp <= entOp[pickIdx];
      issueDataA <= entDataA[pickIdx];
      issueDataB <= entDataB[pickIdx];
      issueConst <= entConst[pickIdx];
      issueIndex <= entIndex[pickIdx];
    end
  end

endmodule

`default_nettype wire

// ==== source/rsParams.svh ====
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

`define RS_ENTRIES 8
`define DATA_WIDTH 32
`define TAG_WIDTH 6
// address offset carried with the store
`define CONST_WIDTH 16
`define INDEX_WIDTH 8
// writeback buses snooped for wake-up
`define RESULT_BUSES 2

`endif

// ==== source/rsPkg.sv ====
`default_nettype none
`include "rsParams.svh"

package rsPkg;

  // store size
  typedef enum logic [1:0] {
    opStoreByte,
    opStoreHalf,
    opStoreWord,
    opStoreDouble
  } storeOp_e;

  typedef enum logic [1:0] {
    entFree,
    entWaiting, // at least one operand outstanding
    entReady
  } entryState_e;

  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`TAG_WIDTH-1:0] tag_t;
  typedef logic [`RS_ENTRIES-1:0] entryMask_t; // bit i is entry i

endpackage

`default_nettype wire

// ==== source/rsStore.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rsParams.svh"

module rsStore import rsPkg::*; (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      stall,
  input  logic                      flush,
  input  logic                      allocValid,
  input  storeOp_e                  allocOp,
  input  logic [`CONST_WIDTH-1:0]   allocConst,
  input  logic [`INDEX_WIDTH-1:0]   allocIndex,
  input  logic                      allocAReady,
  input  data_t                     allocAData,
  input  tag_t                      allocATag,
  input  logic                      allocBReady,
  input  data_t                     allocBData,
  input  tag_t                      allocBTag,
  input  logic [`RESULT_BUSES-1:0]  resultValid,
  input  tag_t [`RESULT_BUSES-1:0]  resultTag,
  input  data_t [`RESULT_BUSES-1:0] resultData,
  output logic                      allocReady,
  output logic                      issueValid,
  output storeOp_e                  issueOp,
  output data_t                     issueDataA,
  output data_t                     issueDataB,
  output logic [`CONST_WIDTH-1:0]   issueConst,
  output logic [`INDEX_WIDTH-1:0]   issueIndex
);

  entryMask_t freeMask;
  entryMask_t readyMask;
  entryMask_t writeSel;
  entryMask_t issueSel;

  storeOp_e                entOp [`RS_ENTRIES];
  data_t                   entDataA [`RS_ENTRIES];
  data_t                   entDataB [`RS_ENTRIES];
  logic [`CONST_WIDTH-1:0] entConst [`RS_ENTRIES];
  logic [`INDEX_WIDTH-1:0] entIndex [`RS_ENTRIES];

  rsAlloc allocUnit (
    .freeMask(freeMask),
    .allocValid(allocValid),
    .stall(stall),
    .writeSel(writeSel),
    .allocReady(allocReady)
  );

  for (genvar i = 0; i < `RS_ENTRIES; i++) begin : entryGen
    rsEntry entryUnit (
      .clk(clk),
      .rstN(rstN),
      .flush(flush),
      .writeEn(writeSel[i]),
      .allocOp(allocOp),
      .allocConst(allocConst),
      .allocIndex(allocIndex),
      .allocAReady(allocAReady),
      .allocAData(allocAData),
      .allocATag(allocATag),
      .allocBReady(allocBReady),
      .allocBData(allocBData),
      .allocBTag(allocBTag),
      .resultValid(resultValid),
      .resultTag(resultTag),
      .resultData(resultData),
      .issueEn(issueSel[i]),
      .isFree(freeMask[i]),
      .isReady(readyMask[i]),
      .entOp(entOp[i]),
      .entDataA(entDataA[i]),
      .entDataB(entDataB[i]),
      .entConst(entConst[i]),
      .entIndex(entIndex[i])
    );
  end

  rsIssue issueUnit (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .flush(flush),
    .readyMask(readyMask),
    .entOp(entOp),
    .entDataA(entDataA),
    .entDataB(entDataB),
    .entConst(entConst),
    .entIndex(entIndex),
    .issueSel(issueSel),
    .issueValid(issueValid),
    .issueOp(issueOp),
    .issueDataA(issueDataA),
    .issueDataB(issueDataB),
    .issueConst(issueConst),
    .issueIndex(issueIndex)
  );

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/rsPkg.sv
source/rsAlloc.sv
source/rsEntry.sv
source/rsIssue.sv
source/rsStore.sv
bench/rsStoreTb.sv
